/* Makefile */
# Verilator build and run of the issue core testbench

VERILATOR ?= verilator
TOP       ?= issue_core_tb
FILELIST  ?= issue_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  issue_pkg::inst_t in_data,
    output logic             in_ready,
    output logic             wb_valid,
    output issue_pkg::wb_t   wb_data
);
    import issue_pkg::*;

    unit_e                      unit;
    logic [SLOT_IDX_BITS-1:0]   lat_idx;
    logic [MUL_LAT-1:0]         slot_r;
    logic [MUL_LAT-1:0]         claim;
    logic                       slot_busy;
    logic                       ready_r;
    logic                       in_fire;
    logic                       alu_fire;
    logic                       mul_fire;
    logic [DATA_BITS-1:0]       alu_result;
    logic [DATA_BITS-1:0]       mul_low;
    logic                       alu_valid;
    wb_t                        alu_wb;
    logic [MUL_LAT-1:0]         mul_valid;
    wb_t                        mul_pipe [MUL_LAT];

    // Unit follows from the opcode
    assign unit = (in_data.op == OP_MUL) ? UNIT_MUL : UNIT_ALU;

    assign lat_idx = (unit == UNIT_MUL) ? SLOT_IDX_BITS'(MUL_LAT - 1)
                                        : SLOT_IDX_BITS'(ALU_LAT - 1);

    // Completion cycle already taken by an older instruction
    assign slot_busy = in_data.wb && slot_r[lat_idx];

    assign in_ready = ready_r && !slot_busy;
    assign in_fire  = in_valid && in_ready;
    assign alu_fire = in_fire && in_data.wb && (unit == UNIT_ALU);
    assign mul_fire = in_fire && in_data.wb && (unit == UNIT_MUL);

    assign claim = (in_fire && in_data.wb) ? (MUL_LAT'(1) << lat_idx) : '0;

    always_comb begin
        case (in_data.op)
            OP_SUB:  alu_result = in_data.a - in_data.b;
            OP_XOR:  alu_result = in_data.a ^ in_data.b;
            default: alu_result = in_data.a + in_data.b;
        endcase
    end

    // Only the low word of the product is kept
    assign mul_low = in_data.a * in_data.b;

    // Bit k marks a writeback k+1 cycles from now
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_r  <= '0;
            ready_r <= 1'b0;
        end else begin
            slot_r  <= (slot_r | claim) >> 1;
            ready_r <= 1'b1;
        end
    end

    // Short pipe, one stage
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_fire;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb.uuid   <= in_data.uuid;
        alu_wb.wid    <= in_data.wid;
        alu_wb.rd     <= in_data.rd;
        alu_wb.result <= alu_result;
    end

    // Long pipe, product formed in the first stage
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_valid <= '0;
        end else begin
            mul_valid <= {mul_valid[MUL_LAT-2:0], mul_fire};
        end
    end

    always_ff @(posedge clk) begin
        mul_pipe[0].uuid   <= in_data.uuid;
        mul_pipe[0].wid    <= in_data.wid;
        mul_pipe[0].rd     <= in_data.rd;
        mul_pipe[0].result <= mul_low;
        for (int i = 1; i < MUL_LAT; i++) begin
            mul_pipe[i] <= mul_pipe[i-1];
        end
    end

    // Reservation keeps the two pipes from finishing together
    assign wb_valid = alu_valid || mul_valid[MUL_LAT-1];
    assign wb_data  = mul_valid[MUL_LAT-1] ? mul_pipe[MUL_LAT-1] : alu_wb;

endmodule

`default_nettype wire

/* hw/inst_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  issue_pkg::inst_t in_data,
    output logic             in_ready,
    output logic             out_valid,
    output issue_pkg::inst_t out_data,
    input  logic             out_ready
);
    import issue_pkg::*;

    inst_t                    mem [IBUF_DEPTH];
    logic [IBUF_PTR_BITS-1:0] rd_ptr;
    logic [IBUF_PTR_BITS-1:0] wr_ptr;
    logic [IBUF_CNT_BITS-1:0] count;
    logic [IBUF_CNT_BITS-1:0] count_next;
    logic                     ready_r;
    logic                     push;
    logic                     pop;

    assign push = in_valid && ready_r;
    assign pop  = out_valid && out_ready;

    assign in_ready  = ready_r;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (!push && pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            ready_r <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == IBUF_PTR_BITS'(IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == IBUF_PTR_BITS'(IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered so the upstream sees a clean ready
            ready_r <= (count_next < IBUF_CNT_BITS'(IBUF_DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hw/issue_core.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  issue_pkg::inst_t                in_data,
    output logic                            in_ready,
    output logic                            wb_valid,
    output issue_pkg::wb_t                  wb_data,
    output logic [issue_pkg::PERF_BITS-1:0] perf_stalls,
    output logic [issue_pkg::PERF_BITS-1:0] perf_fires
);
    import issue_pkg::*;

    // Buffer to scoreboard
    logic  ibuf_valid;
    logic  ibuf_ready;
    inst_t ibuf_data;

    // Scoreboard to execution
    logic  exe_valid;
    logic  exe_ready;
    inst_t exe_data;

    inst_buffer ibuf_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (ibuf_valid),
        .out_data  (ibuf_data),
        .out_ready (ibuf_ready)
    );

    scoreboard scoreboard_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ibuf_valid),
        .in_data     (ibuf_data),
        .in_ready    (ibuf_ready),
        .out_valid   (exe_valid),
        .out_data    (exe_data),
        .out_ready   (exe_ready),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .perf_stalls (perf_stalls),
        .perf_fires  (perf_fires)
    );

    exec_unit exec_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (exe_valid),
        .in_data  (exe_data),
        .in_ready (exe_ready),
        .wb_valid (wb_valid),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // Core geometry
    localparam int NUM_WARPS = 4;
    localparam int NUM_REGS  = 32;
    localparam int WID_BITS  = $clog2(NUM_WARPS);
    localparam int REG_BITS  = $clog2(NUM_REGS);
    localparam int DATA_BITS = 32;
    localparam int UUID_BITS = 8;

    // Instruction buffer sizing
    localparam int IBUF_DEPTH    = 4;
    localparam int IBUF_PTR_BITS = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_BITS = $clog2(IBUF_DEPTH + 1);

    // Pipe latencies in cycles from acceptance to writeback
    localparam int ALU_LAT = 1;
    localparam int MUL_LAT = 3;

    // Index into the writeback slot reservation vector
    localparam int SLOT_IDX_BITS = $clog2(MUL_LAT);

    localparam int PERF_BITS = 16;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_e;

    // Decoded instruction with immediate operands
    typedef struct packed {
        logic [UUID_BITS-1:0] uuid;
        logic [WID_BITS-1:0]  wid;
        op_e                  op;
        logic                 wb;
        logic [REG_BITS-1:0]  rd;
        logic [REG_BITS-1:0]  rs1;
        logic [REG_BITS-1:0]  rs2;
        logic [DATA_BITS-1:0] a;
        logic [DATA_BITS-1:0] b;
    } inst_t;

    // Single-beat writeback
    typedef struct packed {
        logic [UUID_BITS-1:0] uuid;
        logic [WID_BITS-1:0]  wid;
        logic [REG_BITS-1:0]  rd;
        logic [DATA_BITS-1:0] result;
    } wb_t;

endpackage

`default_nettype wire

/* hw/scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreboard (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  issue_pkg::inst_t               in_data,
    output logic                           in_ready,
    output logic                           out_valid,
    output issue_pkg::inst_t               out_data,
    input  logic                           out_ready,
    input  logic                           wb_valid,
    input  issue_pkg::wb_t                 wb_data,
    output logic [issue_pkg::PERF_BITS-1:0] perf_stalls,
    output logic [issue_pkg::PERF_BITS-1:0] perf_fires
);
    import issue_pkg::*;

    // One in-use bit per register of each warp
    logic [NUM_WARPS-1:0][NUM_REGS-1:0] inuse_regs;

    logic       inuse_rd;
    logic       inuse_rs1;
    logic       inuse_rs2;
    logic [2:0] operands_busy;
    logic       operands_ready;
    logic       stg_valid_in;
    logic       stg_ready_in;
    logic       in_fire;
    logic       stall_cycle_r;
    logic       fire_cycle_r;

    assign inuse_rd  = inuse_regs[in_data.wid][in_data.rd];
    assign inuse_rs1 = inuse_regs[in_data.wid][in_data.rs1];
    assign inuse_rs2 = inuse_regs[in_data.wid][in_data.rs2];

    // rd is included to keep same-warp writes in order
    assign operands_busy  = {inuse_rd, inuse_rs1, inuse_rs2};
    assign operands_ready = ~(|operands_busy);

    assign stg_valid_in = in_valid && operands_ready;
    assign in_ready     = stg_ready_in && operands_ready;
    assign in_fire      = in_valid && in_ready;

    stream_buffer staging_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (stg_valid_in),
        .data_in   (in_data),
        .ready_in  (stg_ready_in),
        .valid_out (out_valid),
        .data_out  (out_data),
        .ready_out (out_ready)
    );

    // Set after clear, so a same-cycle set wins
    always_ff @(posedge clk) begin
        if (reset) begin
            inuse_regs <= '0;
        end else begin
            if (wb_valid) begin
                inuse_regs[wb_data.wid][wb_data.rd] <= 1'b0;
            end
            if (in_fire && in_data.wb) begin
                inuse_regs[in_data.wid][in_data.rd] <= 1'b1;
            end
        end
    end

    // Per-cycle events are registered first, counters lag by one
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cycle_r <= 1'b0;
            fire_cycle_r  <= 1'b0;
        end else begin
            stall_cycle_r <= in_valid && !in_ready;
            fire_cycle_r  <= in_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls <= '0;
            perf_fires  <= '0;
        end else begin
            perf_stalls <= perf_stalls + PERF_BITS'(stall_cycle_r);
            perf_fires  <= perf_fires + PERF_BITS'(fire_cycle_r);
        end
    end

endmodule

`default_nettype wire

/* hw/stream_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  issue_pkg::inst_t data_in,
    output logic             ready_in,
    output logic             valid_out,
    output issue_pkg::inst_t data_out,
    input  logic             ready_out
);
    import issue_pkg::*;

    inst_t skid_data;
    logic  skid_valid;
    logic  skid_valid_next;
    logic  out_valid_next;
    logic  ready_r;
    logic  push;
    logic  load_out;

    assign push     = valid_in && ready_r;
    // Output register can take a new beat
    assign load_out = !valid_out || ready_out;
    assign ready_in = ready_r;

    always_comb begin
        out_valid_next  = valid_out;
        skid_valid_next = skid_valid;
        if (load_out) begin
            out_valid_next  = skid_valid || push;
            skid_valid_next = 1'b0;
        end else if (push) begin
            // Downstream stalled, park the beat
            skid_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
            ready_r    <= 1'b0;
        end else begin
            valid_out  <= out_valid_next;
            skid_valid <= skid_valid_next;
            ready_r    <= !skid_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (!load_out && push) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

/* issue_core.f */
hw/issue_pkg.sv
hw/inst_buffer.sv
hw/stream_buffer.sv
hw/scoreboard.sv
hw/exec_unit.sv
hw/issue_core.sv
sim/issue_core_sva.sv
sim/issue_core_checker.sv
sim/issue_core_tb.sv

/* sim/issue_core_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_core_checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wb_valid,
    input  issue_pkg::wb_t                  wb_data,
    input  logic [issue_pkg::PERF_BITS-1:0] perf_stalls,
    input  logic [issue_pkg::PERF_BITS-1:0] perf_fires,
    output int                              wb_count
);
    import issue_pkg::*;

    // Expectations and observations, indexed by uuid
    bit                   known     [2**UUID_BITS];
    string                test_name [2**UUID_BITS];
    inst_t                want_inst [2**UUID_BITS];
    logic [DATA_BITS-1:0] want_res  [2**UUID_BITS];
    int                   after_id  [2**UUID_BITS];
    int                   seen      [2**UUID_BITS];
    int                   seen_seq  [2**UUID_BITS];
    wb_t                  seen_wb   [2**UUID_BITS];
    int                   order_q   [$];
    int                   stray;

    task automatic expect_inst(input string name, input inst_t inst,
                               input logic [DATA_BITS-1:0] res, input int after);
        known[inst.uuid]     = 1'b1;
        test_name[inst.uuid] = name;
        want_inst[inst.uuid] = inst;
        want_res[inst.uuid]  = res;
        after_id[inst.uuid]  = after;
        order_q.push_back(int'(inst.uuid));
    endtask

    // Writeback is a one-cycle pulse, steady at the falling edge
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            wb_count <= wb_count + 1;
            if (!known[wb_data.uuid]) begin
                $display("Writeback with uuid %0d that was never sent", wb_data.uuid);
                stray <= stray + 1;
            end else begin
                seen[wb_data.uuid]     <= seen[wb_data.uuid] + 1;
                seen_seq[wb_data.uuid] <= wb_count + 1;
                seen_wb[wb_data.uuid]  <= wb_data;
            end
        end
    end

    task automatic report(output int errors);
        int u;
        int a;
        int failed;
        int cnt_err;
        bit ok;
        failed  = 0;
        cnt_err = 0;
        foreach (order_q[k]) begin
            u  = order_q[k];
            a  = after_id[u];
            ok = 1'b0;
            if (want_inst[u].wb && seen[u] == 0) begin
                $display("%s: no writeback arrived", test_name[u]);
            end else if (!want_inst[u].wb && seen[u] != 0) begin
                $display("%s: writeback arrived although the wb flag is clear", test_name[u]);
            end else if (seen[u] > 1) begin
                $display("%s: %0d writebacks arrived instead of one", test_name[u], seen[u]);
            end else if (want_inst[u].wb && seen_wb[u].result !== want_res[u]) begin
                $display("** Error %s: expected %h, actual %h",
                         test_name[u], want_res[u], seen_wb[u].result);
            end else if (want_inst[u].wb && {seen_wb[u].wid, seen_wb[u].rd}
                         !== {want_inst[u].wid, want_inst[u].rd}) begin
                $display("** Error %s: expected warp/reg %0d/%0d, actual %0d/%0d", test_name[u],
                         want_inst[u].wid, want_inst[u].rd, seen_wb[u].wid, seen_wb[u].rd);
            end else if (a >= 0 && seen_seq[u] <= seen_seq[a]) begin
                $display("%s: finished before uuid %0d, which it must follow", test_name[u], a);
            end else begin
                ok = 1'b1;
                $display("%s: ok", test_name[u]);
            end
            if (!ok) begin
                failed++;
            end
        end
        if (perf_fires !== PERF_BITS'(order_q.size())) begin
            $display("** Error perf_fires: expected %0d, actual %0d", order_q.size(), perf_fires);
            cnt_err++;
        end
        if (perf_stalls == '0) begin
            $display("perf_stalls stayed at zero although the hazard cases must stall");
            cnt_err++;
        end
        errors = failed + cnt_err + stray;
        $display("Totals: %0d tests, %0d passed, %0d failed, %0d counter errors, %0d stray",
                 order_q.size(), order_q.size() - failed, failed, cnt_err, stray);
    endtask

endmodule

`default_nettype wire

/* sim/issue_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_core_sva (
    input logic                                                   clk,
    input logic                                                   reset,
    input logic                                                   in_valid,
    input logic                                                   in_ready,
    input issue_pkg::inst_t                                       in_data,
    input logic                                                   wb_valid,
    input issue_pkg::wb_t                                         wb_data,
    input logic [issue_pkg::NUM_WARPS-1:0][issue_pkg::NUM_REGS-1:0] inuse_regs
);
    import issue_pkg::*;

    int unsigned fail_count = 0;

    wb_clears_busy_reg: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> inuse_regs[wb_data.wid][wb_data.rd])
        else begin
            fail_count++;
            $error("writeback to warp %0d reg %0d, which was not in use", wb_data.wid, wb_data.rd);
        end

    // A writer taken in holds its rd busy from the next edge on
    accept_marks_rd: assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready && in_data.wb)
        |=> inuse_regs[$past(in_data.wid)][$past(in_data.rd)])
        else begin
            fail_count++;
            $error("accepted instruction left its destination register free");
        end

    // Pipe registers clear on the first reset edge
    no_wb_in_reset: assert property (@(posedge clk) reset |=> !wb_valid)
        else begin
            fail_count++;
            $error("wb_valid high while reset was held");
        end

endmodule

`default_nettype wire

/* sim/issue_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_core_tb;
    import issue_pkg::*;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    inst_t                in_data;
    logic                 in_ready;
    logic                 wb_valid;
    wb_t                  wb_data;
    logic [PERF_BITS-1:0] perf_stalls;
    logic [PERF_BITS-1:0] perf_fires;

    // Stimulus table, uuid equals the row index
    inst_t                stim_q   [$];
    logic [DATA_BITS-1:0] expect_q [$];
    int                   after_q  [$];
    string                name_q   [$];

    integer seed;
    int     wb_seen;
    int     wb_needed;
    int     waited;
    int     errors;
    int     sva_errors;
    bit     timed_out;

    issue_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .perf_stalls (perf_stalls),
        .perf_fires  (perf_fires)
    );

    issue_core_checker check_i (
        .clk         (clk),
        .reset       (reset),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .perf_stalls (perf_stalls),
        .perf_fires  (perf_fires),
        .wb_count    (wb_seen)
    );

    bind scoreboard issue_core_sva sva_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .inuse_regs (inuse_regs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reference result, MUL keeps the low word
    function automatic logic [DATA_BITS-1:0] model_result(input op_e op,
                                                          input logic [DATA_BITS-1:0] a,
                                                          input logic [DATA_BITS-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    task automatic add_test(input string name, input int wid, input op_e op, input bit wb,
                            input int rd, input int rs1, input int rs2, input int after);
        inst_t inst;
        inst.uuid = UUID_BITS'(stim_q.size());
        inst.wid  = WID_BITS'(wid);
        inst.op   = op;
        inst.wb   = wb;
        inst.rd   = REG_BITS'(rd);
        inst.rs1  = REG_BITS'(rs1);
        inst.rs2  = REG_BITS'(rs2);
        inst.a    = $random(seed);
        inst.b    = $random(seed);
        stim_q.push_back(inst);
        expect_q.push_back(model_result(op, inst.a, inst.b));
        after_q.push_back(after);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        // name, warp, op, wb, rd, rs1, rs2, uuid it must follow
        add_test("raw_mul_producer", 0, OP_MUL, 1, 5, 1, 2, -1);
        add_test("raw_add_consumer", 0, OP_ADD, 1, 6, 5, 3, 0);
        add_test("waw_first_mul",    0, OP_MUL, 1, 7, 1, 2, -1);
        add_test("waw_second_xor",   0, OP_XOR, 1, 7, 2, 3, 2);
        add_test("indep_mul_w0",     0, OP_MUL, 1, 8, 1, 2, -1);
        add_test("indep_add_w1",     1, OP_ADD, 1, 8, 1, 2, -1);
        add_test("w1_mul_r9",        1, OP_MUL, 1, 9, 4, 4, -1);
        add_test("w1_sub_reads_r9",  1, OP_SUB, 1, 9, 9, 1, 6);
        add_test("nowb_add",         2, OP_ADD, 0, 1, 3, 4, -1);
        add_test("nowb_xor",         2, OP_XOR, 0, 2, 3, 4, -1);
        add_test("burst_add_r10",    3, OP_ADD, 1, 10, 1, 2, -1);
        add_test("burst_sub_r11",    3, OP_SUB, 1, 11, 1, 2, -1);
        add_test("burst_mul_w2",     2, OP_MUL, 1, 12, 5, 6, -1);
        add_test("burst_xor_r13",    3, OP_XOR, 1, 13, 3, 4, -1);
        add_test("burst_add_w2",     2, OP_ADD, 1, 14, 5, 6, -1);
        add_test("burst_mul_w1",     1, OP_MUL, 1, 15, 2, 3, -1);
        add_test("burst_add_r16",    3, OP_ADD, 1, 16, 5, 6, -1);
        add_test("nowb_mul",         2, OP_MUL, 0, 18, 7, 8, -1);
        add_test("burst_mul_r10",    3, OP_MUL, 1, 10, 1, 2, -1);
        add_test("burst_raw_r10",    3, OP_ADD, 1, 10, 10, 11, 18);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input inst_t inst);
        int count;
        count    = 0;
        in_valid = 1'b1;
        in_data  = inst;
        while (!in_ready && count < 100) begin
            @(negedge clk);
            count++;
        end
        if (!in_ready) begin
            $display("Timed out waiting for in_ready with uuid %0d", inst.uuid);
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
    endtask

    initial begin
        seed      = 32'hb677_9b59;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        timed_out = 1'b0;
        wb_needed = 0;
        build_table();
        foreach (stim_q[i]) begin
            check_i.expect_inst(name_q[i], stim_q[i], expect_q[i], after_q[i]);
            wb_needed += int'(stim_q[i].wb);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Whole table back to back, well past the buffer depth
        foreach (stim_q[i]) begin
            if (!timed_out) begin
                send(stim_q[i]);
            end
        end
        in_valid = 1'b0;

        waited = 0;
        while (!timed_out && wb_seen < wb_needed && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (!timed_out && wb_seen < wb_needed) begin
            $display("Timed out draining, %0d of %0d writebacks seen", wb_seen, wb_needed);
            timed_out = 1'b1;
        end
        // Quiet window catches late extras and the counter lag
        repeat (10) @(negedge clk);

        check_i.report(errors);
        sva_errors = dut_i.scoreboard_i.sva_i.fail_count;
        if (sva_errors != 0) begin
            $display("%0d scoreboard assertion failures", sva_errors);
        end
        if (!timed_out && errors == 0 && sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
